// File: sources.f
+incdir+verif
rtl/particle_pkg.sv
rtl/lane_cmd_if.sv
rtl/lane_result_if.sv
rtl/step_controller.sv
rtl/particle_lane.sv
rtl/update_collector.sv
rtl/particle_box_top.sv
verif/particle_box_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the particle box testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f sources.f --top-module particle_box_tb -o particle_box_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/particle_box_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "tests failed" sim.log; then
	exit 1
fi
exit 0

// File: verif/particle_box_model.svh
`ifndef PARTICLE_BOX_MODEL_SVH
`define PARTICLE_BOX_MODEL_SVH

//////////////////////////////
// Reference particle set
//////////////////////////////
int ref_x [NUM_PARTICLES];
int ref_y [NUM_PARTICLES];
int ref_vx [NUM_PARTICLES];
int ref_vy [NUM_PARTICLES];

// Expected stream of the latest accepted step
pixel_addr_t exp_addr [NUM_SLOTS];
color_t exp_color [NUM_SLOTS];

// Window tally
int window_steps = 0;
int window_hits = 0;
logic exp_hits_valid = 1'b0;
logic [HITS_W-1:0] exp_hits_count = '0;

// Left and right move along x while up and down move along y
function automatic void place_particle(input int lane, input int x, input int y,
		input dir_t dir, input int spd);
	ref_x[lane] = x;
	ref_y[lane] = y;
	ref_vx[lane] = 0;
	ref_vy[lane] = 0;
	case (dir)
		DIR_LEFT: ref_vx[lane] = -spd;
		DIR_UP: ref_vy[lane] = spd;
		DIR_RIGHT: ref_vx[lane] = spd;
		DIR_DOWN: ref_vy[lane] = -spd;
		default: ;
	endcase
endfunction

// One axis against its two walls and whether it flipped
function automatic bit bounce_axis(inout int pos, inout int vel, input int lo, input int hi);
	if (pos <= lo) begin
		vel = -vel;
		pos = lo + 1 + vel;
		return 1'b1;
	end
	if (pos + 1 >= hi) begin
		vel = -vel;
		pos = hi - 1 + vel;
		return 1'b1;
	end
	pos = pos + vel;
	return 1'b0;
endfunction

// Row-major address on the 640 wide screen
function automatic pixel_addr_t frame_addr(input int x, input int y);
	return pixel_addr_t'(y * SCREEN_W + x);
endfunction

//////////////////////////////
// Step prediction
//////////////////////////////
function automatic void predict_step(input int box);
	int half;
	bit hit_x;
	bit hit_y;
	half = box / 2;
	for (int i = 0; i < NUM_PARTICLES; i++) begin
		// Erase old spot first
		exp_addr[2 * i] = frame_addr(ref_x[i], ref_y[i]);
		exp_color[2 * i] = COLOR_BLACK;
		hit_x = bounce_axis(ref_x[i], ref_vx[i], CENTER_X - half, CENTER_X + half);
		hit_y = bounce_axis(ref_y[i], ref_vy[i], CENTER_Y - half, CENTER_Y + half);
		// One hit per lane even when both axes flip
		if (hit_x || hit_y) begin
			window_hits++;
		end
		exp_addr[2 * i + 1] = frame_addr(ref_x[i], ref_y[i]);
		exp_color[2 * i + 1] = COLOR_WHITE;
	end
	window_steps++;
	exp_hits_valid = 1'b0;
	if (window_steps == HITS_WINDOW) begin
		exp_hits_valid = 1'b1;
		exp_hits_count = HITS_W'(window_hits);
		window_steps = 0;
		window_hits = 0;
	end
endfunction

`endif

// File: verif/particle_box_tb.sv
`timescale 1ns/1ps
`default_nettype none

module particle_box_tb import particle_pkg::*; ();

	typedef enum logic [1:0] {
		OP_LOAD,
		OP_STEP,
		OP_DRAIN
	} op_t;

	// One stimulus row
	typedef struct packed {
		logic [8*12-1:0] name;
		op_t op;
		lane_idx_t sel;
		coord_t x;
		coord_t y;
		dir_t dir;
		coord_t box;
		vel_t spd;
	} row_t;

	localparam int NUM_ROWS = 27;
	// Twenty cycles of 40 ns per row plus reset
	localparam int WATCHDOG_NS = (NUM_ROWS * 20 + 10) * 40;

	logic clock;
	logic reset;
	logic load;
	lane_idx_t load_sel;
	coord_t load_x;
	coord_t load_y;
	dir_t load_dir;
	vel_t speed;
	coord_t box_length;
	logic step;
	logic pix_valid;
	pixel_addr_t pix_addr;
	color_t pix_color;
	logic hits_valid;
	logic [HITS_W-1:0] hits_count;

	int row_errors;
	int tests_passed = 0;
	int tests_failed = 0;
	string test_name;

	`include "particle_box_model.svh"

	//////////////////////////////
	// Stimulus table
	//////////////////////////////
	row_t rows [NUM_ROWS] = '{
		// Box 200 with walls at x 220/420 and y 140/340
		'{"free_ld0", OP_LOAD, 2'd0, 10'd300, 10'd200, DIR_LEFT, 10'd200, 10'sd4},
		'{"free_ld1", OP_LOAD, 2'd1, 10'd320, 10'd240, DIR_UP, 10'd200, 10'sd4},
		'{"free_ld2", OP_LOAD, 2'd2, 10'd350, 10'd260, DIR_RIGHT, 10'd200, 10'sd4},
		'{"free_ld3", OP_LOAD, 2'd3, 10'd280, 10'd220, DIR_DOWN, 10'd200, 10'sd4},
		'{"free_move", OP_STEP, 2'd0, 10'd0, 10'd0, DIR_LEFT, 10'd200, 10'sd4},
		// On and below the low walls
		'{"low_ld0", OP_LOAD, 2'd0, 10'd220, 10'd200, DIR_LEFT, 10'd200, 10'sd4},
		'{"low_ld1", OP_LOAD, 2'd1, 10'd300, 10'd138, DIR_DOWN, 10'd200, 10'sd4},
		'{"low_bounce", OP_STEP, 2'd0, 10'd0, 10'd0, DIR_LEFT, 10'd200, 10'sd4},
		'{"low_reverse", OP_STEP, 2'd0, 10'd0, 10'd0, DIR_LEFT, 10'd200, 10'sd4},
		// One short of the high walls
		'{"high_ld2", OP_LOAD, 2'd2, 10'd419, 10'd260, DIR_RIGHT, 10'd200, 10'sd4},
		'{"high_ld3", OP_LOAD, 2'd3, 10'd300, 10'd339, DIR_UP, 10'd200, 10'sd4},
		'{"high_bounce", OP_STEP, 2'd0, 10'd0, 10'd0, DIR_LEFT, 10'd200, 10'sd4},
		// Box 300 with high walls at x 470 and y 390
		'{"wide_ld2", OP_LOAD, 2'd2, 10'd469, 10'd260, DIR_RIGHT, 10'd300, 10'sd4},
		'{"wide_ld3", OP_LOAD, 2'd3, 10'd300, 10'd389, DIR_UP, 10'd300, 10'sd4},
		'{"wide_bounce", OP_STEP, 2'd0, 10'd0, 10'd0, DIR_LEFT, 10'd300, 10'sd4},
		'{"drain_drop", OP_DRAIN, 2'd0, 10'd0, 10'd0, DIR_LEFT, 10'd300, 10'sd4},
		'{"after_drop", OP_STEP, 2'd0, 10'd0, 10'd0, DIR_LEFT, 10'd300, 10'sd4},
		'{"window1_end", OP_STEP, 2'd0, 10'd0, 10'd0, DIR_LEFT, 10'd300, 10'sd4},
		// Second window with a single low wall bounce
		'{"win2_ld0", OP_LOAD, 2'd0, 10'd170, 10'd200, DIR_LEFT, 10'd300, 10'sd4},
		'{"win2_s1", OP_STEP, 2'd0, 10'd0, 10'd0, DIR_LEFT, 10'd300, 10'sd4},
		'{"win2_s2", OP_STEP, 2'd0, 10'd0, 10'd0, DIR_LEFT, 10'd300, 10'sd4},
		'{"win2_s3", OP_STEP, 2'd0, 10'd0, 10'd0, DIR_LEFT, 10'd300, 10'sd4},
		'{"win2_s4", OP_STEP, 2'd0, 10'd0, 10'd0, DIR_LEFT, 10'd300, 10'sd4},
		'{"win2_s5", OP_STEP, 2'd0, 10'd0, 10'd0, DIR_LEFT, 10'd300, 10'sd4},
		'{"win2_s6", OP_STEP, 2'd0, 10'd0, 10'd0, DIR_LEFT, 10'd300, 10'sd4},
		'{"win2_s7", OP_STEP, 2'd0, 10'd0, 10'd0, DIR_LEFT, 10'd300, 10'sd4},
		'{"win2_s8", OP_STEP, 2'd0, 10'd0, 10'd0, DIR_LEFT, 10'd300, 10'sd4}
	};

	particle_box_top particle_box_top_inst (
		.clock(clock),
		.reset(reset),
		.load(load),
		.load_sel(load_sel),
		.load_x(load_x),
		.load_y(load_y),
		.load_dir(load_dir),
		.speed(speed),
		.box_length(box_length),
		.step(step),
		.pix_valid(pix_valid),
		.pix_addr(pix_addr),
		.pix_color(pix_color),
		.hits_valid(hits_valid),
		.hits_count(hits_count)
	);

	always #20 clock = ~clock;

	//////////////////////////////
	// Checks
	//////////////////////////////
	task automatic expect_quiet(input int cycles);
		repeat (cycles) begin
			@(negedge clock);
			assert (!pix_valid && !hits_valid) else begin
				$display("%s: output strobe seen with no step in flight", test_name);
				row_errors++;
			end
		end
	endtask

	task automatic compare_pixel(input int i);
		assert (pix_valid) else begin
			$display("%s: pixel %0d is missing from the stream", test_name, i);
			row_errors++;
		end
		assert (pix_addr == exp_addr[i]) else begin
			$display("MISMATCH %s pixel %0d addr expected %0d actual %0d",
				test_name, i, exp_addr[i], pix_addr);
			row_errors++;
		end
		assert (pix_color == exp_color[i]) else begin
			$display("MISMATCH %s pixel %0d color expected %02h actual %02h",
				test_name, i, exp_color[i], pix_color);
			row_errors++;
		end
	endtask

	// Cycle after the last pixel
	task automatic verify_tail();
		assert (!pix_valid) else begin
			$display("%s: extra pixel after the last slot", test_name);
			row_errors++;
		end
		if (exp_hits_valid) begin
			assert (hits_valid) else begin
				$display("%s: hits pulse missing at the end of the window", test_name);
				row_errors++;
			end
			assert (hits_count == exp_hits_count) else begin
				$display("MISMATCH %s hits_count expected %0d actual %0d",
					test_name, exp_hits_count, hits_count);
				row_errors++;
			end
		end else begin
			assert (!hits_valid) else begin
				$display("%s: hits pulse in the middle of a window", test_name);
				row_errors++;
			end
		end
	endtask

	//////////////////////////////
	// Row operations
	//////////////////////////////
	task automatic drive_load(input row_t row);
		@(posedge clock);
		load <= 1'b1;
		load_sel <= row.sel;
		load_x <= row.x;
		load_y <= row.y;
		load_dir <= row.dir;
		speed <= row.spd;
		box_length <= row.box;
		@(posedge clock);
		load <= 1'b0;
		place_particle(int'(row.sel), int'(row.x), int'(row.y), row.dir, int'(row.spd));
		expect_quiet(2);
	endtask

	task automatic run_step(input row_t row, input bit extra);
		int latency;
		@(posedge clock);
		step <= 1'b1;
		speed <= row.spd;
		box_length <= row.box;
		@(posedge clock);
		step <= 1'b0;
		predict_step(int'(row.box));
		// First pixel due three cycles after acceptance
		latency = 0;
		do begin
			@(negedge clock);
			latency++;
		end while (!pix_valid && latency < 20);
		assert (pix_valid) else begin
			$display("%s: no pixels came out after the step", test_name);
			row_errors++;
		end
		if (!pix_valid) begin
			return;
		end
		assert (latency == 3) else begin
			$display("MISMATCH %s first pixel latency expected 3 actual %0d", test_name, latency);
			row_errors++;
		end
		for (int i = 0; i < NUM_SLOTS; i++) begin
			if (i > 0) begin
				@(negedge clock);
			end
			compare_pixel(i);
			// Mid-drain strobe that must be dropped
			if (extra && i == 2) begin
				@(posedge clock);
				step <= 1'b1;
			end
			if (extra && i == 3) begin
				@(posedge clock);
				step <= 1'b0;
			end
		end
		@(negedge clock);
		verify_tail();
		if (extra) begin
			expect_quiet(6);
		end
	endtask

	task automatic report_test();
		if (row_errors == 0) begin
			tests_passed++;
			$display("PASS %s", test_name);
		end else begin
			tests_failed++;
			$display("FAIL %s with %0d errors", test_name, row_errors);
		end
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////
	initial begin
		clock = 1'b0;
		reset <= 1'b1;
		load <= 1'b0;
		load_sel <= '0;
		load_x <= '0;
		load_y <= '0;
		load_dir <= DIR_LEFT;
		speed <= '0;
		box_length <= '0;
		step <= 1'b0;
		repeat (10) @(posedge clock);
		reset <= 1'b0;

		// Quiet outputs and an empty tally out of reset
		test_name = "reset_idle";
		row_errors = 0;
		expect_quiet(4);
		assert (hits_count == '0) else begin
			$display("MISMATCH %s hits_count expected 0 actual %0d", test_name, hits_count);
			row_errors++;
		end
		report_test();

		for (int r = 0; r < NUM_ROWS; r++) begin
			test_name = string'(rows[r].name);
			row_errors = 0;
			case (rows[r].op)
				OP_LOAD: drive_load(rows[r]);
				OP_STEP: run_step(rows[r], 1'b0);
				default: run_step(rows[r], 1'b1);
			endcase
			report_test();
		end

		$display("summary: %0d of %0d passed, %0d failed",
			tests_passed, tests_passed + tests_failed, tests_failed);
		if (tests_failed == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("timeout: run did not complete within %0d ns", WATCHDOG_NS);
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: rtl/particle_box_top.sv
`timescale 1ns/1ps
`default_nettype none

module particle_box_top import particle_pkg::*; (
	input logic clock,
	input logic reset,
	// Particle load
	input logic load,
	input lane_idx_t load_sel,
	input coord_t load_x,
	input coord_t load_y,
	input dir_t load_dir,
	input vel_t speed,
	// Box and time step
	input coord_t box_length,
	input logic step,
	// Pixel stream
	output logic pix_valid,
	output pixel_addr_t pix_addr,
	output color_t pix_color,
	// Wall hit tally
	output logic hits_valid,
	output logic [HITS_W-1:0] hits_count
);

	logic drain_busy;

	lane_cmd_if cmd_if ();
	lane_result_if res_if [NUM_PARTICLES] ();

	//////////////////////////////
	// Command side
	//////////////////////////////
	step_controller step_controller_inst (
		.clock(clock),
		.reset(reset),
		.load(load),
		.load_sel(load_sel),
		.load_x(load_x),
		.load_y(load_y),
		.load_dir(load_dir),
		.speed(speed),
		.box_length(box_length),
		.step(step),
		.drain_busy(drain_busy),
		.cmd(cmd_if.controller)
	);

	// One lane per particle
	for (genvar i = 0; i < NUM_PARTICLES; i++) begin : g_lane
		particle_lane #(
			.LANE_ID(lane_idx_t'(i))
		) particle_lane_inst (
			.clock(clock),
			.reset(reset),
			.cmd(cmd_if.lane),
			.res(res_if[i].lane)
		);
	end

	//////////////////////////////
	// Pixel and hit output
	//////////////////////////////
	update_collector update_collector_inst (
		.clock(clock),
		.reset(reset),
		.res(res_if),
		.drain_busy(drain_busy),
		.pix_valid(pix_valid),
		.pix_addr(pix_addr),
		.pix_color(pix_color),
		.hits_valid(hits_valid),
		.hits_count(hits_count)
	);

endmodule

`default_nettype wire

// File: rtl/update_collector.sv
`timescale 1ns/1ps
`default_nettype none

module update_collector import particle_pkg::*; (
	input logic clock,
	input logic reset,
	lane_result_if.collector res [NUM_PARTICLES],
	output logic drain_busy,
	// Frame-buffer write stream
	output logic pix_valid,
	output pixel_addr_t pix_addr,
	output color_t pix_color,
	// Wall hits per window
	output logic hits_valid,
	output logic [HITS_W-1:0] hits_count
);

	logic [NUM_PARTICLES-1:0] done_vec;
	logic [NUM_PARTICLES-1:0] hit_vec;
	logic capture;
	logic [HITS_W-1:0] hit_sum;

	// Captured lane results
	coord_t old_x_buf [NUM_PARTICLES];
	coord_t old_y_buf [NUM_PARTICLES];
	coord_t new_x_buf [NUM_PARTICLES];
	coord_t new_y_buf [NUM_PARTICLES];

	logic active;
	logic [SLOT_W-1:0] slot;
	logic last_slot;
	logic [HITS_W-1:0] hit_total;
	logic [WINDOW_W-1:0] step_cnt;

	lane_idx_t pix_lane;
	logic pix_draw;
	coord_t pix_x;
	coord_t pix_y;

	//////////////////////////////
	// Lane capture
	//////////////////////////////
	for (genvar i = 0; i < NUM_PARTICLES; i++) begin : g_tap
		assign done_vec[i] = res[i].done;
		assign hit_vec[i] = res[i].wall_hit;

		always_ff @(posedge clock) begin
			if (capture) begin
				old_x_buf[i] <= res[i].old_x;
				old_y_buf[i] <= res[i].old_y;
				new_x_buf[i] <= res[i].new_x;
				new_y_buf[i] <= res[i].new_y;
			end
		end
	end

	// All lanes finish together
	assign capture = |done_vec;

	// Lanes that bounced this step
	always_comb begin
		hit_sum = '0;
		for (int i = 0; i < NUM_PARTICLES; i++) begin
			hit_sum = hit_sum + HITS_W'(hit_vec[i]);
		end
	end

	assign last_slot = (slot == SLOT_W'(NUM_SLOTS - 1));

	//////////////////////////////
	// Slot walk and hit window
	//////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			active <= 1'b0;
			slot <= '0;
			hit_total <= '0;
			step_cnt <= '0;
			hits_valid <= 1'b0;
			hits_count <= '0;
		end else begin
			hits_valid <= 1'b0;
			if (capture) begin
				active <= 1'b1;
				slot <= '0;
				hit_total <= hit_total + hit_sum;
				step_cnt <= step_cnt + WINDOW_W'(1);
			end else if (active) begin
				slot <= slot + SLOT_W'(1);
				if (last_slot) begin
					active <= 1'b0;
					// Publish once the window's last step has drained
					if (step_cnt == WINDOW_W'(HITS_WINDOW)) begin
						hits_valid <= 1'b1;
						hits_count <= hit_total;
						hit_total <= '0;
						step_cnt <= '0;
					end
				end
			end
		end
	end

	// Even slot erases the old spot, odd slot draws the new one
	assign pix_lane = lane_idx_t'(slot >> 1);
	assign pix_draw = slot[0];
	assign pix_x = pix_draw ? new_x_buf[pix_lane] : old_x_buf[pix_lane];
	assign pix_y = pix_draw ? new_y_buf[pix_lane] : old_y_buf[pix_lane];

	// Row-major frame-buffer address
	assign pix_addr = pixel_addr_t'(pix_y) * pixel_addr_t'(SCREEN_W) + pixel_addr_t'(pix_x);
	assign pix_color = pix_draw ? COLOR_WHITE : COLOR_BLACK;
	assign pix_valid = active;
	assign drain_busy = active;

endmodule

`default_nettype wire

// File: rtl/particle_lane.sv
`timescale 1ns/1ps
`default_nettype none

module particle_lane import particle_pkg::*; #(
	parameter lane_idx_t LANE_ID = '0
) (
	input logic clock,
	input logic reset,
	lane_cmd_if.lane cmd,
	lane_result_if.lane res
);

	// Per-axis outcome of one step
	typedef struct packed {
		coord_t pos;
		vel_t vel;
		logic hit;
	} axis_t;

	particle_t state;
	axis_t next_x;
	axis_t next_y;

	//////////////////////////////
	// Wall bounce on one axis
	//////////////////////////////
	function automatic axis_t bounce(
		input coord_t pos,
		input vel_t vel,
		input coord_t lo,
		input coord_t hi
	);
		axis_t r;
		// Assume a flip and undo it in the free case
		r.hit = 1'b1;
		r.vel = -vel;
		if (pos <= lo) begin
			// Restart just inside the low wall
			r.pos = lo + coord_t'(1) + coord_t'(r.vel);
		end else if (({1'b0, pos} + 11'd1) >= {1'b0, hi}) begin
			// Restart just inside the high wall
			r.pos = hi - coord_t'(1) + coord_t'(r.vel);
		end else begin
			r.hit = 1'b0;
			r.vel = vel;
			r.pos = pos + coord_t'(vel);
		end
		return r;
	endfunction

	always_comb begin
		next_x = bounce(state.x, state.vx, cmd.box_lo_x, cmd.box_hi_x);
		next_y = bounce(state.y, state.vy, cmd.box_lo_y, cmd.box_hi_y);
	end

	// Particle state and done strobe
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= '0;
			res.done <= 1'b0;
		end else begin
			res.done <= cmd.step;
			if (cmd.load && (cmd.load_sel == LANE_ID)) begin
				state <= cmd.load_state;
			end else if (cmd.step) begin
				state <= '{x: next_x.pos, y: next_y.pos, vx: next_x.vel, vy: next_y.vel};
			end
		end
	end

	// Result published alongside done
	always_ff @(posedge clock) begin
		if (cmd.step) begin
			res.old_x <= state.x;
			res.old_y <= state.y;
			res.new_x <= next_x.pos;
			res.new_y <= next_y.pos;
			res.wall_hit <= next_x.hit | next_y.hit;
		end
	end

endmodule

`default_nettype wire

// File: rtl/step_controller.sv
`timescale 1ns/1ps
`default_nettype none

module step_controller import particle_pkg::*; (
	input logic clock,
	input logic reset,
	// Particle load request
	input logic load,
	input lane_idx_t load_sel,
	input coord_t load_x,
	input coord_t load_y,
	input dir_t load_dir,
	input vel_t speed,
	// Full box edge length in pixels
	input coord_t box_length,
	input logic step,
	// Collector still sending pixels
	input logic drain_busy,
	lane_cmd_if.controller cmd
);

	vel_t load_vx;
	vel_t load_vy;
	coord_t half_len;
	logic in_flight;
	logic drain_busy_q;
	logic drain_done;
	logic step_ok;

	//////////////////////////////
	// Direction to velocity
	//////////////////////////////
	always_comb begin
		load_vx = '0;
		load_vy = '0;
		case (load_dir)
			// Negative x
			DIR_LEFT: load_vx = -speed;
			DIR_UP: load_vy = speed;
			DIR_RIGHT: load_vx = speed;
			// Negative y
			DIR_DOWN: load_vy = -speed;
			default: load_vx = '0;
		endcase
	end

	// Half the edge on each side of the centre
	assign half_len = box_length >> 1;

	// Collector just went idle
	assign drain_done = drain_busy_q & ~drain_busy;

	// A step is dropped while the previous one drains,
	// and also when it collides with a load
	assign step_ok = step & ~load & (~in_flight | drain_done);

	//////////////////////////////
	// Strobes and in-flight flag
	//////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			cmd.load <= 1'b0;
			cmd.step <= 1'b0;
			in_flight <= 1'b0;
			drain_busy_q <= 1'b0;
		end else begin
			cmd.load <= load;
			cmd.step <= step_ok;
			drain_busy_q <= drain_busy;
			// Busy from issue until the last pixel leaves
			if (step_ok) begin
				in_flight <= 1'b1;
			end else if (drain_done) begin
				in_flight <= 1'b0;
			end
		end
	end

	// Load payload for the selected lane
	always_ff @(posedge clock) begin
		if (load) begin
			cmd.load_sel <= load_sel;
			cmd.load_state <= '{x: load_x, y: load_y, vx: load_vx, vy: load_vy};
		end
	end

	// Bounds latched with each accepted step
	always_ff @(posedge clock) begin
		if (step_ok) begin
			cmd.box_lo_x <= coord_t'(CENTER_X) - half_len;
			cmd.box_hi_x <= coord_t'(CENTER_X) + half_len;
			cmd.box_lo_y <= coord_t'(CENTER_Y) - half_len;
			cmd.box_hi_y <= coord_t'(CENTER_Y) + half_len;
		end
	end

endmodule

`default_nettype wire

// File: rtl/lane_result_if.sv
`timescale 1ns/1ps
`default_nettype none

// One lane's step result toward the pixel collector
interface lane_result_if import particle_pkg::*; ();

	// Pulses in the same cycle for all lanes
	logic done;
	// Position before the step
	coord_t old_x;
	coord_t old_y;
	// Position after the step
	coord_t new_x;
	coord_t new_y;
	// Either axis bounced this step
	logic wall_hit;

	modport lane (
		output done,
		output old_x,
		output old_y,
		output new_x,
		output new_y,
		output wall_hit
	);

	modport collector (
		input done,
		input old_x,
		input old_y,
		input new_x,
		input new_y,
		input wall_hit
	);

endinterface

`default_nettype wire

// File: rtl/lane_cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

// Broadcast from the step controller to every particle lane
interface lane_cmd_if import particle_pkg::*; ();

	// Load one lane with a fresh particle
	logic load;
	lane_idx_t load_sel;
	particle_t load_state;

	// Advance all lanes by one time step
	logic step;

	// Wall positions
	// held steady between steps
	coord_t box_lo_x;
	coord_t box_hi_x;
	coord_t box_lo_y;
	coord_t box_hi_y;

	modport controller (
		output load,
		output load_sel,
		output load_state,
		output step,
		output box_lo_x,
		output box_hi_x,
		output box_lo_y,
		output box_hi_y
	);

	modport lane (
		input load,
		input load_sel,
		input load_state,
		input step,
		input box_lo_x,
		input box_hi_x,
		input box_lo_y,
		input box_hi_y
	);

endinterface

`default_nettype wire

// File: rtl/particle_pkg.sv
`default_nettype none

package particle_pkg;

	//////////////////////////////
	// Screen and box geometry
	//////////////////////////////
	localparam int SCREEN_W = 640;
	localparam int SCREEN_H = 480;
	// Box is centred on the screen
	localparam int CENTER_X = SCREEN_W / 2;
	localparam int CENTER_Y = SCREEN_H / 2;

	// Particle set
	localparam int NUM_PARTICLES = 4;
	// Erase then draw for every particle
	localparam int NUM_SLOTS = 2 * NUM_PARTICLES;
	localparam int SLOT_W = $clog2(NUM_SLOTS);

	// Wall hit window in steps
	localparam int HITS_WINDOW = 8;
	localparam int HITS_W = 4;
	localparam int WINDOW_W = $clog2(HITS_WINDOW + 1);

	//////////////////////////////
	// Types
	//////////////////////////////
	typedef logic [9:0] coord_t;
	typedef logic signed [9:0] vel_t;
	typedef logic [18:0] pixel_addr_t;
	// RGB332
	typedef logic [7:0] color_t;
	typedef logic [$clog2(NUM_PARTICLES)-1:0] lane_idx_t;

	// Axis direction of travel
	typedef enum logic [1:0] {
		DIR_LEFT = 2'd0,
		DIR_UP = 2'd1,
		DIR_RIGHT = 2'd2,
		DIR_DOWN = 2'd3
	} dir_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
		vel_t vx;
		vel_t vy;
	} particle_t;

	// Pixel colours
	localparam color_t COLOR_BLACK = 8'h00;
	localparam color_t COLOR_WHITE = 8'hff;

endpackage

`default_nettype wire
